// ==== source/redmule_pkg.sv ====
// Shared types of the integer matrix-multiply accelerator
// Register offsets are byte addresses on the 8-bit register port
`default_nettype none

package redmule_pkg;

  // X and W elements
  typedef logic signed [7:0] elem_t;

  // Y biases, partial sums and Z results, wrapping modulo 2^32
  typedef logic signed [31:0] acc_t;

  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  typedef struct packed {
    logic      req;
    logic      we;
    reg_addr_t addr;
    reg_data_t wdata;
  } periph_req_t;

  typedef struct packed {
    logic      gnt;
    logic      r_valid;
    reg_data_t rdata;
  } periph_rsp_t;

  // Job command from the controller, start is a single-cycle pulse
  typedef struct packed {
    logic      start;
    reg_data_t m_rows;
  } sched_cmd_t;

  typedef enum logic [1:0] {
    IDLE,
    LOAD_W,
    COMPUTE,
    DRAIN
  } sched_state_e;

  localparam reg_addr_t RegMRows   = 8'h00;
  localparam reg_addr_t RegStatus  = 8'h04;
  localparam reg_addr_t RegTrigger = 8'h54;

endpackage : redmule_pkg

`default_nettype wire

// ==== source/redmule_ctrl.sv ====
// Register port and job control, one job at a time
// Trigger writes while busy or with M equal to zero are dropped
`default_nettype none

module redmule_ctrl (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  redmule_pkg::periph_req_t periph_req_i,
  output redmule_pkg::periph_rsp_t periph_rsp_o,
  input  logic                     job_done_i,
  output redmule_pkg::sched_cmd_t  sched_cmd_o,
  output logic                     busy_o,
  output logic                     evt_o
);

  redmule_pkg::reg_data_t m_rows_q;
  redmule_pkg::reg_data_t rdata_d;
  redmule_pkg::reg_data_t rdata_q;
  logic                   r_valid_q;
  logic                   busy_q;
  logic                   evt_q;
  logic                   wr_en;
  logic                   rd_en;
  logic                   start;

  assign wr_en = periph_req_i.req && periph_req_i.we;
  assign rd_en = periph_req_i.req && !periph_req_i.we;

  // Job starts only from idle with a nonzero row count
  assign start = wr_en && (periph_req_i.addr == redmule_pkg::RegTrigger) &&
                 !busy_q && (m_rows_q != '0);

  always_comb begin
    rdata_d = '0;
    case (periph_req_i.addr)
      redmule_pkg::RegMRows:  rdata_d = m_rows_q;
      redmule_pkg::RegStatus: rdata_d = {31'd0, busy_q};
      default:                rdata_d = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      m_rows_q  <= '0;
      r_valid_q <= 1'b0;
      busy_q    <= 1'b0;
      evt_q     <= 1'b0;
    end else begin
      if (wr_en && (periph_req_i.addr == redmule_pkg::RegMRows) && !busy_q) begin
        m_rows_q <= periph_req_i.wdata;
      end
      r_valid_q <= rd_en;
      if (start) begin
        busy_q <= 1'b1;
      end else if (job_done_i) begin
        busy_q <= 1'b0;
      end
      evt_q <= job_done_i;
    end
  end

  // Read data captured with each read request
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      rdata_q <= rdata_d;
    end
  end

  assign periph_rsp_o.gnt     = periph_req_i.req;
  assign periph_rsp_o.r_valid = r_valid_q;
  assign periph_rsp_o.rdata   = rdata_q;

  assign sched_cmd_o.start  = start;
  assign sched_cmd_o.m_rows = m_rows_q;

  assign busy_o = busy_q;
  assign evt_o  = evt_q;

endmodule : redmule_ctrl

`default_nettype wire

// ==== source/redmule_scheduler.sv ====
// Job sequencer: weight load, row issue, then wait for every Z row to leave
// X and Y are always accepted together as one issue
`default_nettype none

module redmule_scheduler (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  redmule_pkg::sched_cmd_t sched_cmd_i,
  input  logic                    w_valid_i,
  output logic                    w_ready_o,
  input  logic                    w_loaded_i,
  input  logic                    x_valid_i,
  input  logic                    y_valid_i,
  output logic                    xy_ready_o,
  input  logic                    engine_adv_i,
  output logic                    issue_o,
  input  logic                    z_pop_i,
  output logic                    job_done_o
);

  redmule_pkg::sched_state_e state_q;
  redmule_pkg::sched_state_e state_d;
  redmule_pkg::reg_data_t    issued_q;
  redmule_pkg::reg_data_t    popped_q;
  logic                      last_issue;
  logic                      last_pop;

  // Ready drops as soon as the buffer holds Height rows
  assign w_ready_o = (state_q == redmule_pkg::LOAD_W) && !w_loaded_i && w_valid_i;

  assign xy_ready_o = (state_q == redmule_pkg::COMPUTE) && x_valid_i && y_valid_i &&
                      engine_adv_i && (issued_q < sched_cmd_i.m_rows);
  assign issue_o    = xy_ready_o;

  assign last_issue = issue_o && (issued_q == sched_cmd_i.m_rows - 1);
  assign last_pop   = z_pop_i && (popped_q == sched_cmd_i.m_rows - 1);

  // Pops may already happen while rows are still being issued
  assign job_done_o = (state_q == redmule_pkg::DRAIN) && last_pop;

  always_comb begin
    state_d = state_q;
    case (state_q)
      redmule_pkg::IDLE: begin
        if (sched_cmd_i.start) state_d = redmule_pkg::LOAD_W;
      end
      redmule_pkg::LOAD_W: begin
        if (w_loaded_i) state_d = redmule_pkg::COMPUTE;
      end
      redmule_pkg::COMPUTE: begin
        if (last_issue) state_d = redmule_pkg::DRAIN;
      end
      redmule_pkg::DRAIN: begin
        if (last_pop) state_d = redmule_pkg::IDLE;
      end
      default: state_d = redmule_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q  <= redmule_pkg::IDLE;
      issued_q <= '0;
      popped_q <= '0;
    end else begin
      state_q <= state_d;
      if (sched_cmd_i.start) begin
        issued_q <= '0;
        popped_q <= '0;
      end else begin
        if (issue_o) issued_q <= issued_q + 1;
        if (z_pop_i) popped_q <= popped_q + 1;
      end
    end
  end

endmodule : redmule_scheduler

`default_nettype wire

// ==== source/redmule_w_buffer.sv ====
// Weight store, Height rows of Width elements written in order
// The matrix is held unchanged until the next job starts loading
`default_nettype none

module redmule_w_buffer #(
  parameter int unsigned Height = 4,
  parameter int unsigned Width  = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      start_i,
  input  logic                                      w_push_i,
  input  redmule_pkg::elem_t [Width-1:0]            w_row_i,
  output logic                                      w_loaded_o,
  output redmule_pkg::elem_t [Height-1:0][Width-1:0] w_matrix_o
);

  localparam int unsigned CntW = $clog2(Height + 1);

  redmule_pkg::elem_t [Height-1:0][Width-1:0] w_matrix_q;
  logic [CntW-1:0]                           row_cnt_q;

  // Row pointer doubles as the loaded-row count
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      row_cnt_q <= '0;
    end else if (start_i) begin
      row_cnt_q <= '0;
    end else if (w_push_i && !w_loaded_o) begin
      row_cnt_q <= row_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_push_i && !w_loaded_o) begin
      w_matrix_q[row_cnt_q] <= w_row_i;
    end
  end

  assign w_loaded_o = (row_cnt_q == CntW'(Height));
  assign w_matrix_o = w_matrix_q;

endmodule : redmule_w_buffer

`default_nettype wire

// ==== source/redmule_engine.sv ====
// Two-stage integer MAC pipeline: products, then bias plus column sums
// The whole pipe stalls together when the last stage cannot hand off
`default_nettype none

module redmule_engine #(
  parameter int unsigned Height = 4,
  parameter int unsigned Width  = 4
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  input  logic                                      issue_i,
  input  redmule_pkg::elem_t [Height-1:0]           x_row_i,
  input  redmule_pkg::acc_t  [Width-1:0]            y_row_i,
  input  redmule_pkg::elem_t [Height-1:0][Width-1:0] w_matrix_i,
  input  logic                                      out_full_i,
  output logic                                      adv_o,
  output logic                                      z_valid_o,
  output redmule_pkg::acc_t  [Width-1:0]            z_row_o
);

  redmule_pkg::acc_t [Height-1:0][Width-1:0] s1_prod_q;
  redmule_pkg::acc_t [Width-1:0]             s1_bias_q;
  redmule_pkg::acc_t [Width-1:0]             s2_sum_q;
  redmule_pkg::acc_t [Width-1:0]             col_sum;
  logic                                      s1_valid_q;
  logic                                      s2_valid_q;

  assign adv_o     = !s2_valid_q || !out_full_i;
  // Handoff strobe into the output buffer
  assign z_valid_o = s2_valid_q && !out_full_i;
  assign z_row_o   = s2_sum_q;

  // Adder tree per column, sums wrap at 32 bits
  always_comb begin
    for (int w = 0; w < Width; w++) begin
      col_sum[w] = s1_bias_q[w];
      for (int h = 0; h < Height; h++) begin
        col_sum[w] = col_sum[w] + s1_prod_q[h][w];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (adv_o) begin
      s1_valid_q <= issue_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (adv_o && issue_i) begin
      for (int h = 0; h < Height; h++) begin
        for (int w = 0; w < Width; w++) begin
          s1_prod_q[h][w] <= redmule_pkg::acc_t'(x_row_i[h]) *
                             redmule_pkg::acc_t'(w_matrix_i[h][w]);
        end
      end
      s1_bias_q <= y_row_i;
    end
    if (adv_o && s1_valid_q) begin
      s2_sum_q <= col_sum;
    end
  end

endmodule : redmule_engine

`default_nettype wire

// ==== source/redmule_z_buffer.sv ====
// Two-entry Z output FIFO, data held stable until accepted
// Pushes are only issued while the FIFO is not full
`default_nettype none

module redmule_z_buffer #(
  parameter int unsigned Width = 4
) (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          push_i,
  input  redmule_pkg::acc_t [Width-1:0] row_i,
  output logic                          full_o,
  output logic                          z_valid_o,
  output redmule_pkg::acc_t [Width-1:0] z_data_o,
  input  logic                          z_ready_i,
  output logic                          pop_o
);

  redmule_pkg::acc_t [Width-1:0] mem_q [2];
  logic                          wptr_q;
  logic                          rptr_q;
  logic [1:0]                    count_q;

  assign z_valid_o = (count_q != 2'd0);
  assign full_o    = (count_q == 2'd2);
  assign z_data_o  = mem_q[rptr_q];
  assign pop_o     = z_valid_o && z_ready_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wptr_q  <= 1'b0;
      rptr_q  <= 1'b0;
      count_q <= 2'd0;
    end else begin
      if (push_i) wptr_q <= ~wptr_q;
      if (pop_o) rptr_q <= ~rptr_q;
      case ({push_i, pop_o})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wptr_q] <= row_i;
    end
  end

endmodule : redmule_z_buffer

`default_nettype wire

// ==== source/redmule_top.sv ====
// Matrix-multiply accelerator top, Z = Y + X*W on 8-bit signed inputs
// W must be fully loaded before X and Y rows are taken
`default_nettype none

module redmule_top #(
  parameter int unsigned Height = 4,
  parameter int unsigned Width  = 4
) (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  redmule_pkg::periph_req_t       periph_req_i,
  output redmule_pkg::periph_rsp_t       periph_rsp_o,
  output logic                           busy_o,
  output logic                           evt_o,
  input  logic                           w_valid_i,
  input  redmule_pkg::elem_t [Width-1:0] w_data_i,
  output logic                           w_ready_o,
  input  logic                           x_valid_i,
  input  redmule_pkg::elem_t [Height-1:0] x_data_i,
  output logic                           x_ready_o,
  input  logic                           y_valid_i,
  input  redmule_pkg::acc_t  [Width-1:0] y_data_i,
  output logic                           y_ready_o,
  output logic                           z_valid_o,
  output redmule_pkg::acc_t  [Width-1:0] z_data_o,
  input  logic                           z_ready_i
);

  redmule_pkg::sched_cmd_t                   sched_cmd;
  redmule_pkg::elem_t [Height-1:0][Width-1:0] w_matrix;
  redmule_pkg::acc_t  [Width-1:0]            eng_z_row;
  logic                                      job_done;
  logic                                      w_loaded;
  logic                                      engine_adv;
  logic                                      issue;
  logic                                      xy_ready;
  logic                                      eng_z_valid;
  logic                                      z_full;
  logic                                      z_pop;

  assign x_ready_o = xy_ready;
  assign y_ready_o = xy_ready;

  redmule_ctrl u_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .periph_req_i (periph_req_i),
    .periph_rsp_o (periph_rsp_o),
    .job_done_i   (job_done),
    .sched_cmd_o  (sched_cmd),
    .busy_o       (busy_o),
    .evt_o        (evt_o)
  );

  // W ready already includes valid, so it is the push strobe
  redmule_scheduler u_scheduler (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .sched_cmd_i (sched_cmd),
    .w_valid_i (w_valid_i), .w_ready_o (w_ready_o), .w_loaded_i (w_loaded),
    .x_valid_i (x_valid_i), .y_valid_i (y_valid_i), .xy_ready_o (xy_ready),
    .engine_adv_i (engine_adv), .issue_o (issue), .z_pop_i (z_pop),
    .job_done_o (job_done)
  );

  redmule_w_buffer #(.Height(Height), .Width(Width)) u_w_buffer (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .start_i (sched_cmd.start),
    .w_push_i (w_ready_o), .w_row_i (w_data_i), .w_loaded_o (w_loaded),
    .w_matrix_o (w_matrix)
  );

  redmule_engine #(.Height(Height), .Width(Width)) u_engine (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .issue_i (issue), .x_row_i (x_data_i),
    .y_row_i (y_data_i), .w_matrix_i (w_matrix), .out_full_i (z_full),
    .adv_o (engine_adv), .z_valid_o (eng_z_valid), .z_row_o (eng_z_row)
  );

  redmule_z_buffer #(.Width(Width)) u_z_buffer (
    .clk_i (clk_i), .rst_n_i (rst_n_i), .push_i (eng_z_valid), .row_i (eng_z_row),
    .full_o (z_full), .z_valid_o (z_valid_o), .z_data_o (z_data_o),
    .z_ready_i (z_ready_i), .pop_o (z_pop)
  );

endmodule : redmule_top

`default_nettype wire

// ==== tests/tb_redmule_top.sv ====
// Self-checking testbench for the accelerator at default Height and Width
// Stream data, valid gaps and Z back-pressure come from seeded LFSR streams
`default_nettype none

module tb_redmule_top;

  localparam int Height    = 4;
  localparam int Width     = 4;
  localparam int NumJobs   = 3;
  localparam int ClkPeriod = 8;
  // Generous cycle budget per streamed row and per job for the watchdog
  localparam int RowCycles = 40;
  localparam int JobCycles = 200;

  typedef redmule_pkg::elem_t [Height-1:0]            x_row_t;
  typedef redmule_pkg::elem_t [Width-1:0]             w_row_t;
  typedef redmule_pkg::acc_t  [Width-1:0]             z_row_t;
  typedef redmule_pkg::elem_t [Height-1:0][Width-1:0] w_mat_t;

  int unsigned job_m [NumJobs] = '{5, 9, 3};

  logic                     clk        = 1'b0;
  logic                     rst_n      = 1'b0;
  redmule_pkg::periph_req_t periph_req = '0;
  redmule_pkg::periph_rsp_t periph_rsp;
  logic                     busy;
  logic                     evt;
  logic                     w_valid    = 1'b0;
  w_row_t                   w_data     = '0;
  logic                     w_ready;
  logic                     x_valid    = 1'b0;
  x_row_t                   x_data     = '0;
  logic                     x_ready;
  logic                     y_valid    = 1'b0;
  z_row_t                   y_data     = '0;
  logic                     y_ready;
  logic                     z_valid;
  z_row_t                   z_data;
  logic                     z_ready    = 1'b0;
  logic [7:0]               ctl_outs;

  logic [31:0] data_lfsr  = 32'd32;
  logic [31:0] rdy_lfsr   = 32'd32;
  logic        rdy_random = 1'b0;
  w_mat_t      w_model;
  z_row_t      exp_q [$];
  z_row_t      held_data;
  logic        held       = 1'b0;
  logic        last_xfer  = 1'b0;
  int unsigned rows_seen  = 0;
  int unsigned evt_cnt    = 0;
  int unsigned cur_m      = 0;

  redmule_top u_redmule_top (
    .clk_i (clk), .rst_n_i (rst_n), .periph_req_i (periph_req), .periph_rsp_o (periph_rsp),
    .busy_o (busy), .evt_o (evt),
    .w_valid_i (w_valid), .w_data_i (w_data), .w_ready_o (w_ready),
    .x_valid_i (x_valid), .x_data_i (x_data), .x_ready_o (x_ready),
    .y_valid_i (y_valid), .y_data_i (y_data), .y_ready_o (y_ready),
    .z_valid_o (z_valid), .z_data_o (z_data), .z_ready_i (z_ready)
  );

  assign ctl_outs = {busy, evt, z_valid, w_ready, x_ready, y_ready,
                     periph_rsp.gnt, periph_rsp.r_valid};

  always #(ClkPeriod / 2) clk = ~clk;

  task automatic fail_and_stop(input string why);
    $display("%s", why);
    $display("Test failures found");
    $fatal(1);
  endtask

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) n = n ^ 32'h8020_0003;
    return n;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], data_lfsr[0]};
      data_lfsr = lfsr_step(data_lfsr);
    end
  endtask

  // Z = Y + X*W per column, wrapping at 32 bits
  function automatic z_row_t model_row(input x_row_t x, input z_row_t y, input w_mat_t wm);
    z_row_t z;
    int     acc;
    for (int c = 0; c < Width; c++) begin
      acc = y[c];
      for (int r = 0; r < Height; r++) begin
        acc += int'(x[r]) * int'(wm[r][c]);
      end
      z[c] = acc;
    end
    return z;
  endfunction

  assert property (@(posedge clk) !rst_n |-> (ctl_outs == 8'h00))
    else fail_and_stop($sformatf("[FAIL] reset outputs expected 00 got %h", ctl_outs));
  assert property (@(posedge clk) disable iff (!rst_n) (z_valid && !z_ready) |=> z_valid)
    else fail_and_stop("z_valid_o dropped before the Z row was accepted");
  assert property (@(posedge clk) disable iff (!rst_n) evt |=> !evt)
    else fail_and_stop("evt_o stayed high for more than one cycle");

  // Output monitor, sampled mid-cycle where every signal is settled
  always @(negedge clk) begin
    if (rst_n) begin
      if (held) begin
        assert (z_data == held_data)
          else fail_and_stop($sformatf("[FAIL] z_data_o expected %h got %h", held_data, z_data));
      end
      if (evt) begin
        assert (rows_seen == cur_m)
          else fail_and_stop($sformatf("[FAIL] Z rows per job expected %h got %h",
                                       cur_m, rows_seen));
        assert (last_xfer && !busy)
          else fail_and_stop("evt_o did not follow the last Z transfer with busy_o low");
        rows_seen = 0;
        evt_cnt++;
      end
      last_xfer = z_valid && z_ready;
      if (z_valid && z_ready) begin
        assert (exp_q.size() > 0) else fail_and_stop("a Z row arrived with none expected");
        assert (z_data == exp_q[0])
          else fail_and_stop($sformatf("[FAIL] z_data_o expected %h got %h", exp_q[0], z_data));
        void'(exp_q.pop_front());
        rows_seen++;
      end
      held      = z_valid && !z_ready;
      held_data = z_data;
    end
  end

  always @(posedge clk) begin
    #1;
    if (rdy_random) begin
      z_ready  = rdy_lfsr[0];
      rdy_lfsr = lfsr_step(rdy_lfsr);
    end else begin
      z_ready = rst_n;
    end
  end

  task automatic reg_access(input logic we, input redmule_pkg::reg_addr_t addr,
                            input redmule_pkg::reg_data_t wdata,
                            output redmule_pkg::reg_data_t rdata);
    @(posedge clk);
    #1;
    periph_req.req   = 1'b1;
    periph_req.we    = we;
    periph_req.addr  = addr;
    periph_req.wdata = wdata;
    @(negedge clk);
    assert (periph_rsp.gnt && !periph_rsp.r_valid)
      else fail_and_stop("gnt missing or r_valid early on a register request");
    @(posedge clk);
    #1;
    periph_req.req = 1'b0;
    rdata = '0;
    if (!we) begin
      @(negedge clk);
      assert (periph_rsp.r_valid) else fail_and_stop("r_valid missing one cycle after a read");
      rdata = periph_rsp.rdata;
    end
  endtask

  task automatic reg_write(input redmule_pkg::reg_addr_t addr,
                           input redmule_pkg::reg_data_t data);
    redmule_pkg::reg_data_t unused;
    reg_access(1'b1, addr, data, unused);
  endtask

  task automatic reg_expect(input redmule_pkg::reg_addr_t addr,
                            input redmule_pkg::reg_data_t exp, input string name);
    redmule_pkg::reg_data_t got;
    reg_access(1'b0, addr, '0, got);
    assert (got == exp) else fail_and_stop($sformatf("[FAIL] %s expected %h got %h",
                                                     name, exp, got));
  endtask

  // Optional idle cycles before valid rises, valid then holds until the transfer
  task automatic idle_gaps(input logic gaps);
    logic [31:0] r;
    r = '0;
    if (gaps) take_bits(1, r);
    while (r[0]) begin
      @(posedge clk);
      #1;
      take_bits(1, r);
    end
  endtask

  task automatic send_w_row(input w_row_t row, input logic gaps);
    @(posedge clk);
    #1;
    idle_gaps(gaps);
    w_data  = row;
    w_valid = 1'b1;
    @(negedge clk);
    while (!w_ready) @(negedge clk);
    @(posedge clk);
    #1;
    w_valid = 1'b0;
  endtask

  task automatic send_xy_row(input x_row_t x, input z_row_t y, input logic gaps);
    @(posedge clk);
    #1;
    idle_gaps(gaps);
    x_data  = x;
    y_data  = y;
    x_valid = 1'b1;
    y_valid = 1'b1;
    @(negedge clk);
    while (!(x_ready && y_ready)) @(negedge clk);
    exp_q.push_back(model_row(x, y, w_model));
    @(posedge clk);
    #1;
    x_valid = 1'b0;
    y_valid = 1'b0;
  endtask

  task automatic run_job(input int unsigned m, input logic gaps);
    x_row_t      xr;
    z_row_t      yr;
    logic [31:0] v;
    int unsigned evt_before;
    cur_m      = m;
    rdy_random = gaps;
    evt_before = evt_cnt;
    reg_write(redmule_pkg::RegMRows, m);
    reg_expect(redmule_pkg::RegMRows, m, "RegMRows");
    reg_write(redmule_pkg::RegTrigger, 32'd1);
    @(negedge clk);
    assert (busy) else fail_and_stop("busy_o did not rise after the trigger write");
    reg_expect(redmule_pkg::RegStatus, 32'd1, "RegStatus during job");
    // A row count write while busy is ignored
    reg_write(redmule_pkg::RegMRows, m + 7);
    reg_expect(redmule_pkg::RegMRows, m, "RegMRows while busy");
    for (int h = 0; h < Height; h++) begin
      for (int c = 0; c < Width; c++) begin
        take_bits(8, v);
        w_model[h][c] = v[7:0];
      end
      send_w_row(w_model[h], gaps);
    end
    for (int unsigned i = 0; i < m; i++) begin
      for (int h = 0; h < Height; h++) begin
        take_bits(8, v);
        xr[h] = v[7:0];
      end
      for (int c = 0; c < Width; c++) begin
        take_bits(32, v);
        yr[c] = v;
      end
      send_xy_row(xr, yr, gaps);
      // A trigger with rows already issued must leave the row counters alone
      if (i == m / 2) reg_write(redmule_pkg::RegTrigger, 32'd1);
    end
    wait (evt_cnt == evt_before + 1);
    reg_expect(redmule_pkg::RegStatus, 32'd0, "RegStatus after job");
    repeat (4) @(posedge clk);
    assert (evt_cnt == evt_before + 1)
      else fail_and_stop($sformatf("[FAIL] evt_o pulses expected %h got %h",
                                   evt_before + 1, evt_cnt));
  endtask

  task automatic zero_m_trigger();
    @(posedge clk);
    #1;
    w_valid = 1'b1;
    reg_write(redmule_pkg::RegMRows, 32'd0);
    reg_expect(redmule_pkg::RegMRows, 32'd0, "RegMRows");
    reg_write(redmule_pkg::RegTrigger, 32'd1);
    repeat (3) begin
      @(negedge clk);
      assert (!busy && !w_ready) else fail_and_stop("a trigger with M equal to zero started a job");
    end
    @(posedge clk);
    #1;
    w_valid = 1'b0;
  endtask

  initial begin
    int unsigned cycles;
    cycles = JobCycles * NumJobs;
    for (int j = 0; j < NumJobs; j++) begin
      cycles += RowCycles * (job_m[j] + Height);
    end
    #(cycles * ClkPeriod);
    fail_and_stop("Watchdog timeout, the tests did not finish in time");
  end

  initial begin
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    assert (ctl_outs == 8'h00)
      else fail_and_stop($sformatf("[FAIL] outputs after reset expected 00 got %h", ctl_outs));
    zero_m_trigger();
    // First job without gaps or back-pressure, then randomized jobs with new W and M
    for (int j = 0; j < NumJobs; j++) begin
      run_job(job_m[j], j != 0);
    end
    $display("All tests passed!");
    $finish;
  end

endmodule : tb_redmule_top

`default_nettype wire

// ==== list.f ====
source/redmule_pkg.sv
source/redmule_ctrl.sv
source/redmule_scheduler.sv
source/redmule_w_buffer.sv
source/redmule_engine.sv
source/redmule_z_buffer.sv
source/redmule_top.sv
tests/tb_redmule_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_redmule_top
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= All tests passed!

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
